//--- hw/tree_route_pkg.sv
/* tree route shared types */
`default_nettype none

package tree_route_pkg;

    // ========================================
    // tree shape
    // ========================================
    localparam int TREE_K = 2;                      // children per router
    localparam int TREE_L = 3;                      // levels, 0 is the leaf row
    localparam int NUM_EP = TREE_K ** TREE_L;       // endpoints under the root

    localparam int DIGIT_W = $clog2(TREE_K);        // one base-K digit
    localparam int LEVEL_W = $clog2(TREE_L + 1);    // room for root + 1 on look-ahead
    localparam int PORT_W  = $clog2(TREE_K + 1);    // down ports 0..K-1, up is K
    localparam int EP_W    = $clog2(NUM_EP);

    typedef logic [EP_W-1:0]    ep_t;
    typedef logic [PORT_W-1:0]  port_t;
    typedef logic [LEVEL_W-1:0] level_t;
    typedef logic [TREE_L-1:0][DIGIT_W-1:0] digits_t;   // digit 0 is least significant

    localparam port_t UP_PORT = port_t'(TREE_K);

    // ========================================
    // payloads
    // ========================================
    typedef struct packed {
        ep_t    dest;           // destination endpoint
        level_t cur_level;
        ep_t    cur_index;      // row index inside the level
        port_t  in_port;
    } route_req_t;

    typedef struct packed {
        digits_t cur_digits;    // cur_index * K^lvl in digits
        level_t  cur_level;
        digits_t dest_digits;
        port_t   in_port;
    } route_addr_t;

    typedef struct packed {
        port_t  port;           // this router's output port
        port_t  lk_port;        // next router's output port
        logic   lk_eject;
        port_t  in_port;
    } route_dec_t;

    typedef struct packed {
        logic [TREE_K-1:0] port_mask;   // one-hot without the input port
        port_t             lk_port;
        logic              lk_eject;
    } route_out_t;

endpackage

`default_nettype wire

//--- hw/pipe_stage.sv
/* one-entry pipeline register */
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      reset,
    input  payload_t in_data,
    input  wire      in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  wire      out_ready
);

    logic     full;
    payload_t data_q;

    // take a new item when empty or when the current one leaves
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;              // load on handshake
        end
    end

    assign out_data  = data_q;
    assign out_valid = full;

endmodule

`default_nettype wire

//--- hw/route_in.sv
/* header to digit address */
`default_nettype none

module route_in
    import tree_route_pkg::*;
(
    input  route_req_t  req,
    output route_addr_t addr
);

    ep_t scale;         // K^lvl
    ep_t fat_pos;       // fat-tree equivalent position

    // split a position into base-K digits, lowest first
    function automatic digits_t to_digits(input ep_t pos);
        digits_t d;
        ep_t     rest;
        rest = pos;
        for (int i = 0; i < TREE_L; i++) begin
            d[i] = DIGIT_W'(rest % TREE_K);
            rest = ep_t'(rest / TREE_K);
        end
        return d;
    endfunction

    always_comb begin
        scale = ep_t'(1);
        for (int i = 0; i < TREE_L - 1; i++) begin
            if (i < req.cur_level) begin
                scale = ep_t'(scale * TREE_K);
            end
        end
        fat_pos = ep_t'(req.cur_index * scale);

        // a router at lvl holds its row index in digits lvl and up
        addr.cur_digits  = to_digits(fat_pos);
        addr.cur_level   = req.cur_level;
        addr.dest_digits = to_digits(req.dest);
        addr.in_port     = req.in_port;
    end

endmodule

`default_nettype wire

//--- hw/nca_route.sv
/* nearest common ancestor port */
`default_nettype none

module nca_route
    import tree_route_pkg::*;
(
    input  digits_t cur_digits,
    input  level_t  cur_level,
    input  digits_t dest_digits,
    output port_t   port
);

    logic mismatch;     // dest outside this subtree

    // ========================================
    // ancestor compare
    // ========================================
    // The router position is shifted one digit down against the
    // destination: router digit i-1 lines up with dest digit i.
    // Only digits above the current level take part.
    always_comb begin
        mismatch = 1'b0;
        for (int i = 1; i < TREE_L; i++) begin
            if ((i > cur_level) && (cur_digits[i-1] != dest_digits[i])) begin
                mismatch = 1'b1;
            end
        end
    end

    // up when outside, else the dest digit at this level
    assign port = mismatch ? UP_PORT : port_t'(dest_digits[cur_level]);

endmodule

`default_nettype wire

//--- hw/lookahead_route.sv
/* look-ahead route for the next hop */
`default_nettype none

module lookahead_route
    import tree_route_pkg::*;
(
    input  digits_t cur_digits,
    input  level_t  cur_level,
    input  digits_t dest_digits,
    input  port_t   port,
    output port_t   lk_port,
    output logic    lk_eject
);

    digits_t nxt_digits;
    level_t  nxt_level;
    port_t   nxt_port;

    // ========================================
    // next router address
    // ========================================
    always_comb begin
        nxt_digits = cur_digits;
        nxt_level  = cur_level;
        if (port == UP_PORT) begin
            nxt_digits[cur_level] = '0;                 // parent index j/K
            nxt_level = level_t'(cur_level + 1'b1);
        end else if (cur_level != '0) begin
            nxt_digits[cur_level - 1'b1] = port[DIGIT_W-1:0];  // child j*K+p
            nxt_level = level_t'(cur_level - 1'b1);
        end
    end

    nca_route next_hop (
        .cur_digits  (nxt_digits),
        .cur_level   (nxt_level),
        .dest_digits (dest_digits),
        .port        (nxt_port)
    );

    // a leaf going down leaves the tree
    assign lk_eject = (port != UP_PORT) && (cur_level == '0);
    assign lk_port  = lk_eject ? '0 : nxt_port;

endmodule

`default_nettype wire

//--- hw/route_out.sv
/* port decode and credit output */
`default_nettype none

module route_out
    import tree_route_pkg::*;
#(
    parameter int CREDITS = 4
) (
    input  wire        clk,
    input  wire        reset,
    input  route_dec_t dec,
    input  wire        dec_valid,
    output logic       dec_ready,
    output route_out_t out,
    output logic       out_valid,
    input  wire        credit_return
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credits;
    logic [TREE_K:0]  port_hot;     // K down ports plus up

    // ========================================
    // credit counter
    // ========================================
    assign out_valid = dec_valid && (credits != '0);
    assign dec_ready = out_valid;   // stage B drains on delivery

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= CNT_W'(CREDITS);
        end else if (out_valid && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (credit_return && !out_valid && (credits != CNT_W'(CREDITS))) begin
            credits <= credits + 1'b1;  // saturate at CREDITS
        end
    end

    // ========================================
    // decode and input port removal
    // ========================================
    always_comb begin
        port_hot = '0;
        port_hot[dec.port] = 1'b1;
        for (int i = 0; i < TREE_K; i++) begin
            // bits above in_port move down one
            out.port_mask[i] = (i < dec.in_port) ? port_hot[i] : port_hot[i+1];
        end
        out.lk_port  = dec.lk_port;
        out.lk_eject = dec.lk_eject;
    end

endmodule

`default_nettype wire

//--- hw/tree_route_top.sv
/* tree route unit top */
`default_nettype none

module tree_route_top
    import tree_route_pkg::*;
#(
    parameter int OUT_CREDITS = 4
) (
    input  wire        clk,
    input  wire        reset,
    input  route_req_t req,
    input  wire        req_valid,
    output logic       req_ready,
    output route_out_t out,
    output logic       out_valid,
    input  wire        credit_return
);

    route_addr_t addr_d;
    route_addr_t addr_q;
    logic        a_valid;
    logic        b_ready;
    wire route_dec_t dec_d;     // filled member by member
    route_dec_t  dec_q;
    logic        b_valid;
    logic        o_ready;

    route_in u_route_in (.req(req), .addr(addr_d));

    pipe_stage #(.payload_t(route_addr_t)) stage_a (
        .clk(clk), .reset(reset),
        .in_data(addr_d), .in_valid(req_valid), .in_ready(req_ready),
        .out_data(addr_q), .out_valid(a_valid), .out_ready(b_ready)
    );

    nca_route u_nca (
        .cur_digits(addr_q.cur_digits), .cur_level(addr_q.cur_level),
        .dest_digits(addr_q.dest_digits), .port(dec_d.port)
    );

    lookahead_route u_lookahead (
        .cur_digits(addr_q.cur_digits), .cur_level(addr_q.cur_level),
        .dest_digits(addr_q.dest_digits), .port(dec_d.port),
        .lk_port(dec_d.lk_port), .lk_eject(dec_d.lk_eject)
    );

    assign dec_d.in_port = addr_q.in_port;

    pipe_stage #(.payload_t(route_dec_t)) stage_b (
        .clk(clk), .reset(reset),
        .in_data(dec_d), .in_valid(a_valid), .in_ready(b_ready),
        .out_data(dec_q), .out_valid(b_valid), .out_ready(o_ready)
    );

    route_out #(.CREDITS(OUT_CREDITS)) u_route_out (
        .clk(clk), .reset(reset),
        .dec(dec_q), .dec_valid(b_valid), .dec_ready(o_ready),
        .out(out), .out_valid(out_valid), .credit_return(credit_return)
    );

endmodule

`default_nettype wire

//--- include/tb_route_checks.svh
/* route reference model and checks */
`ifndef TB_ROUTE_CHECKS_SVH
`define TB_ROUTE_CHECKS_SVH

// port of router (lvl, j) toward dest
function automatic int unsigned ref_port(input int unsigned lvl, input int unsigned j,
                                         input int unsigned dest);
    if ((dest / (TREE_K ** (lvl + 1))) != j) begin
        return TREE_K;                              // outside the subtree
    end
    return (dest / (TREE_K ** lvl)) % TREE_K;
endfunction

function automatic route_out_t expected_route(input route_req_t r);
    route_out_t  res;
    int unsigned p;
    p = ref_port(r.cur_level, r.cur_index, r.dest);
    res.port_mask = '0;
    if (p < r.in_port) begin
        res.port_mask[p] = 1'b1;
    end else if (p > r.in_port) begin
        res.port_mask[p - 1] = 1'b1;                // one slot lower past the input port
    end
    res.lk_eject = 1'b0;
    if (p == TREE_K) begin
        res.lk_port = port_t'(ref_port(r.cur_level + 1, r.cur_index / TREE_K, r.dest));
    end else if (r.cur_level == 0) begin
        res.lk_port  = '0;                          // ejection
        res.lk_eject = 1'b1;
    end else begin
        res.lk_port = port_t'(ref_port(r.cur_level - 1, r.cur_index * TREE_K + p, r.dest));
    end
    return res;
endfunction

task automatic report_error(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    $display("Error: %s got %0h expected %0h", name, got, exp);
    $display("SOME TESTS FAILED");
    $fatal(1);
endtask

task automatic check_mask(input route_out_t got, input route_out_t exp);
    if (got.port_mask !== exp.port_mask) begin
        report_error("port_mask", 32'(got.port_mask), 32'(exp.port_mask));
    end
endtask

task automatic check_lookahead(input route_out_t got, input route_out_t exp);
    if (got.lk_port !== exp.lk_port) begin
        report_error("lk_port", 32'(got.lk_port), 32'(exp.lk_port));
    end
    if (got.lk_eject !== exp.lk_eject) begin
        report_error("lk_eject", 32'(got.lk_eject), 32'(exp.lk_eject));
    end
endtask

`endif

//--- tests/tb_tree_route.sv
/* tree route unit testbench */
`default_nettype none

module tb_tree_route
    import tree_route_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int OUT_CREDITS  = 4;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RAND     = 100;
    localparam int STALL_HDRS   = 8;        // enough to fill both stages past the credits
    localparam int STALL_CYCLES = 60;

    logic        clk;
    logic        reset;
    route_req_t  req;
    logic        req_valid;
    logic        req_ready;
    route_out_t  rsp;
    logic        out_valid;
    logic        credit_return;

    route_out_t  exp_q[$];                  // expected results in order
    int unsigned acc_q[$];                  // acceptance edge per header
    bit          timed_q[$];                // latency checked for this header
    int unsigned cycle = 0;
    int unsigned n_accepted = 0;
    int unsigned n_delivered = 0;
    bit          auto_return = 1'b1;
    bit          delivered_last = 1'b0;
    int unsigned manual_credits = 0;

    `include "tb_route_checks.svh"

    tree_route_top #(.OUT_CREDITS(OUT_CREDITS)) uut (
        .clk(clk), .reset(reset),
        .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .out(rsp), .out_valid(out_valid), .credit_return(credit_return)
    );

    // ========================================
    // helpers
    // ========================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    function automatic int directed_count();
        int n;
        n = 0;
        for (int lvl = 0; lvl < TREE_L; lvl++) begin
            n += (TREE_K ** (TREE_L - 1 - lvl)) * NUM_EP
                 * ((lvl == TREE_L - 1) ? TREE_K : TREE_K + 1);
        end
        return n;
    endfunction

    // legal router, root never entered from above
    function automatic route_req_t random_header();
        route_req_t  r;
        int unsigned lvl;
        lvl = $urandom % TREE_L;
        r.cur_level = level_t'(lvl);
        r.cur_index = ep_t'($urandom % (TREE_K ** (TREE_L - 1 - lvl)));
        r.dest      = ep_t'($urandom % NUM_EP);
        r.in_port   = port_t'($urandom % ((lvl == TREE_L - 1) ? TREE_K : TREE_K + 1));
        return r;
    endfunction

    // called on a rising edge, returns on the edge that accepts
    task automatic send_header(input route_req_t r, input bit timed);
        bit          accepted;
        int unsigned acc;
        accepted = 1'b0;
        #2;
        req       = r;
        req_valid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready;
            acc = cycle + 1;
            @(posedge clk);
        end
        exp_q.push_back(expected_route(r));
        acc_q.push_back(acc);
        timed_q.push_back(timed);
        n_accepted++;
    endtask

    task automatic drive_idle();
        #2;
        req_valid = 1'b0;
        req       = '0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(posedge clk);          // let the last credits come back
    endtask

    // ========================================
    // clock, credits, watchdog
    // ========================================
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        #2;
        if (auto_return) begin
            credit_return = delivered_last;
        end else if (manual_credits > 0) begin
            credit_return = 1'b1;
            manual_credits--;
        end else begin
            credit_return = 1'b0;
        end
    end

    initial begin : watchdog
        int limit;
        limit = RESET_CYCLES + 4 * (directed_count() + NUM_RAND + STALL_HDRS) + STALL_CYCLES;
        forever begin
            @(posedge clk);
            cycle++;
            if (cycle > limit) begin
                abort_run("timeout: the DUT stopped delivering results");
            end
        end
    end

    // ========================================
    // scoreboard
    // ========================================
    initial begin : compare_results
        route_out_t  exp;
        int unsigned acc;
        bit          timed;
        forever begin
            @(negedge clk);
            delivered_last = out_valid;
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("a result came out with no header outstanding");
                end
                exp   = exp_q.pop_front();
                acc   = acc_q.pop_front();
                timed = timed_q.pop_front();
                check_mask(rsp, exp);
                check_lookahead(rsp, exp);
                if (timed && (cycle + 1 - acc != 2)) begin
                    report_error("out_valid latency", 32'(cycle + 1 - acc), 32'd2);
                end
                n_delivered++;
            end
        end
    end

    // ========================================
    // stimulus
    // ========================================
    initial begin : stimulus
        route_req_t  r;
        int unsigned stall_base;
        void'($urandom(84806));
        reset         = 1'b1;
        req           = '0;
        req_valid     = 1'b0;
        credit_return = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;
        @(negedge clk);
        if (out_valid || !req_ready) begin
            abort_run("after reset out_valid must be low and req_ready high");
        end

        // every router, destination and input port
        @(posedge clk);
        for (int lvl = 0; lvl < TREE_L; lvl++) begin
            for (int j = 0; j < TREE_K ** (TREE_L - 1 - lvl); j++) begin
                for (int d = 0; d < NUM_EP; d++) begin
                    for (int ip = 0; ip <= ((lvl == TREE_L - 1) ? TREE_K - 1 : TREE_K); ip++) begin
                        r.cur_level = level_t'(lvl);
                        r.cur_index = ep_t'(j);
                        r.dest      = ep_t'(d);
                        r.in_port   = port_t'(ip);
                        send_header(r, 1'b1);
                    end
                end
            end
        end
        drive_idle();
        wait_drained();

        for (int n = 0; n < NUM_RAND; n++) begin
            send_header(random_header(), 1'b1);
        end
        drive_idle();
        wait_drained();

        // credits withheld, then released
        auto_return = 1'b0;
        stall_base  = n_delivered;
        fork
            begin
                for (int n = 0; n < STALL_HDRS; n++) begin
                    send_header(random_header(), 1'b0);
                end
                drive_idle();
            end
            begin
                do @(negedge clk); while (req_ready);
                repeat (6) @(negedge clk);
                if (n_delivered - stall_base != OUT_CREDITS) begin
                    report_error("results during stall", 32'(n_delivered - stall_base),
                                 32'(OUT_CREDITS));
                end
                if (out_valid || req_ready) begin
                    abort_run("out_valid or req_ready high with no credits left");
                end
                manual_credits = STALL_HDRS;
            end
        join
        wait_drained();

        if ((exp_q.size() != 0) || (n_delivered != n_accepted)) begin
            $display("Error: delivered %0h accepted %0h", n_delivered, n_accepted);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
hw/tree_route_pkg.sv
hw/pipe_stage.sv
hw/route_in.sv
hw/nca_route.sv
hw/lookahead_route.sv
hw/route_out.sv
hw/tree_route_top.sv
tests/tb_tree_route.sv

//--- Bender.yml
package:
  name: tree_route

sources:
  - files:
      - hw/tree_route_pkg.sv
      - hw/pipe_stage.sv
      - hw/route_in.sv
      - hw/nca_route.sv
      - hw/lookahead_route.sv
      - hw/route_out.sv
      - hw/tree_route_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_tree_route.sv
